/* tb/freq_stim.dat */
// adc_half ref_half gates reset_flag exp_adc exp_ref, all hex
// half periods in ns, zero stops that clock; expected count zero means dead
0005 0032 0006 0000 031f 004f
0008 0019 0006 0000 01f3 009f
// ADC clock stopped
0000 0032 0006 0000 0000 004f
// ADC restarts, ref stopped
0005 0000 0006 0000 031f 0000
// Mid-run reset, ref restarts
0005 0032 0006 0001 031f 004f
0008 0032 0006 0000 01f3 004f

/* vlog.f */
verilog/freq_meter_pkg.sv
verilog/flag_sync.sv
verilog/gate_timer.sv
verilog/freq_channel.sv
verilog/freq_meter_top.sv
tb/freq_meter_asserts.sv
tb/freq_checker.sv
tb/tb_freq_meter.sv

/* tb/tb_freq_meter.sv */
`timescale 1ns/1ns

module tb_freq_meter;

    import freq_meter_pkg::*;

    localparam gate_cnt_t GATE_CYCLES = 200;
    localparam int        MAX_PHASES  = 16;

    logic      ps_clk = 1'b0;
    logic      rst_n_i = 1'b1;
    logic      adc_clk_i = 1'b0;
    logic      ref_clk_i = 1'b0;
    freq_cnt_t adc_freq_o;
    freq_cnt_t ref_freq_o;
    logic      adc_freq_upd_o;
    logic      ref_freq_upd_o;
    logic      adc_clk_dead_o;
    logic      ref_clk_dead_o;

    int        adc_half = 0;
    int        ref_half = 0;
    logic      phase_start = 1'b0;
    freq_cnt_t exp_adc = '0;
    freq_cnt_t exp_ref = '0;
    int        adc_errs;
    int        ref_errs;
    logic      read_done = 1'b0;
    longint    limit_ns;

    logic [15:0] stim_mem [0:MAX_PHASES*6-1];
    int          n_phases;
    int          total_gates;

    always #20 ps_clk = ~ps_clk;

    // Half period of zero parks the clock low
    always begin
        if (adc_half == 0) begin
            adc_clk_i = 1'b0;
            @(adc_half);
        end else begin
            #(adc_half) adc_clk_i = ~adc_clk_i;
        end
    end

    always begin
        if (ref_half == 0) begin
            ref_clk_i = 1'b0;
            @(ref_half);
        end else begin
            #(ref_half) ref_clk_i = ~ref_clk_i;
        end
    end

    freq_meter_top #(.GATE_CYCLES(GATE_CYCLES)) i_dut (.*);

    freq_checker #(.CH_NAME("adc"), .GATE_CYCLES(GATE_CYCLES)) i_adc_chk (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .phase_start_i (phase_start),
        .exp_i         (exp_adc),
        .freq_i        (adc_freq_o),
        .upd_i         (adc_freq_upd_o),
        .dead_i        (adc_clk_dead_o),
        .err_cnt_o     (adc_errs)
    );

    freq_checker #(.CH_NAME("ref"), .GATE_CYCLES(GATE_CYCLES)) i_ref_chk (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .phase_start_i (phase_start),
        .exp_i         (exp_ref),
        .freq_i        (ref_freq_o),
        .upd_i         (ref_freq_upd_o),
        .dead_i        (ref_clk_dead_o),
        .err_cnt_o     (ref_errs)
    );

    initial begin
        wait (read_done);
        limit_ns = longint'(total_gates) * GATE_CYCLES * 40 * 2 + 10000;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        int asrt_errs;
        for (int i = 0; i < MAX_PHASES * 6; i++) stim_mem[i] = '0;
        $readmemh("tb/freq_stim.dat", stim_mem);
        n_phases    = 0;
        total_gates = 0;
        while (n_phases < MAX_PHASES && stim_mem[n_phases*6+2] != 0) begin
            total_gates += stim_mem[n_phases*6+2];
            n_phases++;
        end
        read_done = 1'b1;

        for (int p = 0; p < n_phases; p++) begin
            @(posedge ps_clk);
            adc_half <= stim_mem[p*6];
            ref_half <= stim_mem[p*6+1];
            exp_adc  <= stim_mem[p*6+4];
            exp_ref  <= stim_mem[p*6+5];
            if (p == 0 || stim_mem[p*6+3] != 0) begin
                rst_n_i <= 1'b0;
                repeat (3) @(posedge ps_clk);
                rst_n_i <= 1'b1;
            end
            phase_start <= 1'b1;
            @(posedge ps_clk);
            phase_start <= 1'b0;
            repeat (stim_mem[p*6+2] * GATE_CYCLES - 1) @(posedge ps_clk);
        end

        asrt_errs = i_dut.u_asserts.fail_cnt;
        $display("Errors: adc %0d, ref %0d, assertions %0d", adc_errs, ref_errs, asrt_errs);
        if (adc_errs + ref_errs + asrt_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/freq_checker.sv */
`timescale 1ns/1ns

module freq_checker #(
    parameter string                     CH_NAME     = "adc",
    parameter freq_meter_pkg::gate_cnt_t GATE_CYCLES = 200
) (
    input  logic                      ps_clk,
    input  logic                      rst_n_i,
    input  logic                      phase_start_i,
    input  freq_meter_pkg::freq_cnt_t exp_i,
    input  freq_meter_pkg::freq_cnt_t freq_i,
    input  logic                      upd_i,
    input  logic                      dead_i,
    output int                        err_cnt_o
);

    import freq_meter_pkg::*;

    localparam int SKEW = SYNC_STAGES + 3;  // Crossing jitter on the done path

    int   errs  = 0;
    int   n_upd = 0;
    int   since = 0;
    logic seen  = 1'b0;

    assign err_cnt_o = errs;

    task automatic fail_val(input string sig, input longint exp, input longint got);
        errs++;
        $display("FAIL %0t ns %s_%s expected %0d got %0d", $time, CH_NAME, sig, exp, got);
    endtask

    task automatic check_update();
        int diff;
        diff = int'(freq_i) - int'(exp_i);
        if (exp_i == '0) begin      // Stopped clock
            if (dead_i !== 1'b1) fail_val("clk_dead_o", 1, dead_i);
            if (freq_i !== '0) fail_val("freq_o", 0, freq_i);
        end else begin
            if (dead_i !== 1'b0) fail_val("clk_dead_o", 0, dead_i);
            if (diff > 1 || diff < -1) fail_val("freq_o", exp_i, freq_i);
        end
    endtask

    always @(posedge ps_clk) begin
        if (!rst_n_i) begin
            if (freq_i !== '0) fail_val("freq_o", 0, freq_i);
            if (upd_i !== 1'b0) fail_val("freq_upd_o", 0, upd_i);
            if (dead_i !== 1'b0) fail_val("clk_dead_o", 0, dead_i);
            seen  = 1'b0;
            n_upd = 0;
            since = 0;
        end else begin
            if (phase_start_i) n_upd = 0;
            since++;
            if (!seen && !upd_i) begin
                // Still in the reset state
                if (freq_i !== '0) fail_val("freq_o", 0, freq_i);
                if (dead_i !== 1'b0) fail_val("clk_dead_o", 0, dead_i);
            end
            if (upd_i) begin
                seen = 1'b1;
                n_upd++;
                if (n_upd > 2) check_update();
                if (n_upd > 3 && (since < GATE_CYCLES - SKEW || since > GATE_CYCLES + SKEW)) begin
                    errs++;
                    $display("%s updates %0d cycles apart at %0t ns, one per gate expected",
                             CH_NAME, since, $time);
                end
                since = 0;
            end
        end
    end

endmodule

/* tb/freq_meter_asserts.sv */
`timescale 1ns/1ns

module freq_meter_asserts #(
    parameter freq_meter_pkg::gate_cnt_t GATE_CYCLES = 200
) (
    input logic                      ps_clk,
    input logic                      rst_n_i,
    input logic                      gate_stb_i,
    input freq_meter_pkg::freq_cnt_t adc_freq_i,
    input freq_meter_pkg::freq_cnt_t ref_freq_i,
    input logic                      adc_upd_i,
    input logic                      ref_upd_i,
    input logic                      adc_dead_i,
    input logic                      ref_dead_i
);

    import freq_meter_pkg::*;

    gate_cnt_t gap_q;       // Cycles since the last gate
    logic      seen_q;
    int        fail_cnt = 0;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gap_q  <= '0;
            seen_q <= 1'b0;
        end else if (gate_stb_i) begin
            gap_q  <= 32'd1;
            seen_q <= 1'b1;
        end else begin
            gap_q <= gap_q + 1'b1;
        end
    end

    a_gate_gap: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        gate_stb_i && seen_q |-> gap_q == GATE_CYCLES)
        else begin
            fail_cnt++;
            $error("gate strobe spacing is not GATE_CYCLES");
        end

    a_adc_upd_w: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        adc_upd_i |=> !adc_upd_i)
        else begin
            fail_cnt++;
            $error("adc update strobe longer than one cycle");
        end

    a_ref_upd_w: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        ref_upd_i |=> !ref_upd_i)
        else begin
            fail_cnt++;
            $error("ref update strobe longer than one cycle");
        end

    a_adc_chg: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $changed(adc_freq_i) |-> adc_upd_i)
        else begin
            fail_cnt++;
            $error("adc result changed without update");
        end

    a_ref_chg: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $changed(ref_freq_i) |-> ref_upd_i)
        else begin
            fail_cnt++;
            $error("ref result changed without update");
        end

    a_adc_dead: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $rose(adc_dead_i) |-> $past(gate_stb_i))
        else begin
            fail_cnt++;
            $error("adc dead rose without a gate");
        end

    a_ref_dead: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $rose(ref_dead_i) |-> $past(gate_stb_i))
        else begin
            fail_cnt++;
            $error("ref dead rose without a gate");
        end

endmodule

// Top level holds both the gate and GATE_CYCLES
bind freq_meter_top freq_meter_asserts #(.GATE_CYCLES(GATE_CYCLES)) u_asserts (
    .ps_clk     (ps_clk),
    .rst_n_i    (rst_n_i),
    .gate_stb_i (gate_stb),
    .adc_freq_i (adc_freq_o),
    .ref_freq_i (ref_freq_o),
    .adc_upd_i  (adc_freq_upd_o),
    .ref_upd_i  (ref_freq_upd_o),
    .adc_dead_i (adc_clk_dead_o),
    .ref_dead_i (ref_clk_dead_o)
);

/* verilog/freq_meter_top.sv */
`timescale 1ns/1ns

module freq_meter_top #(
    parameter freq_meter_pkg::gate_cnt_t GATE_CYCLES = freq_meter_pkg::GATE_CYCLES_DEF
) (
    input  logic                      ps_clk,
    input  logic                      rst_n_i,
    input  logic                      adc_clk_i,
    input  logic                      ref_clk_i,
    output freq_meter_pkg::freq_cnt_t adc_freq_o,
    output freq_meter_pkg::freq_cnt_t ref_freq_o,
    output logic                      adc_freq_upd_o,
    output logic                      ref_freq_upd_o,
    output logic                      adc_clk_dead_o,
    output logic                      ref_clk_dead_o
);

    logic gate_stb;     // Shared by both channels

    gate_timer #(
        .GATE_CYCLES (GATE_CYCLES)
    ) u_gate (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n_i),
        .gate_stb_o (gate_stb)
    );

    // ADC sample clock
    freq_channel u_adc_chan (
        .ps_clk     (ps_clk),
        .meas_clk_i (adc_clk_i),
        .rst_n_i    (rst_n_i),
        .gate_stb_i (gate_stb),
        .freq_o     (adc_freq_o),
        .freq_upd_o (adc_freq_upd_o),
        .clk_dead_o (adc_clk_dead_o)
    );

    // PL reference clock
    freq_channel u_ref_chan (
        .ps_clk     (ps_clk),
        .meas_clk_i (ref_clk_i),
        .rst_n_i    (rst_n_i),
        .gate_stb_i (gate_stb),
        .freq_o     (ref_freq_o),
        .freq_upd_o (ref_freq_upd_o),
        .clk_dead_o (ref_clk_dead_o)
    );

endmodule

/* verilog/freq_channel.sv */
`timescale 1ns/1ns

module freq_channel (
    input  logic                      ps_clk,
    input  logic                      meas_clk_i,
    input  logic                      rst_n_i,
    input  logic                      gate_stb_i,
    output freq_meter_pkg::freq_cnt_t freq_o,
    output logic                      freq_upd_o,
    output logic                      clk_dead_o
);

    import freq_meter_pkg::*;

    logic        gate_meas;     // Gate strobe, measured domain
    logic        done_ps;       // Count is back, ps_clk domain

    freq_cnt_t   edge_cnt_q;
    freq_cnt_t   cnt_hold_q;

    chan_state_t state_q;
    chan_state_t state_d;

    freq_cnt_t   freq_q;
    logic        upd_q;
    logic        dead_q;

    flag_sync u_gate_sync (
        .clk_a_i  (ps_clk),
        .clk_b_i  (meas_clk_i),
        .rst_n_i  (rst_n_i),
        .flag_a_i (gate_stb_i),
        .flag_b_o (gate_meas)
    );

    // Same pulse sent straight back marks the count as ready
    flag_sync u_done_sync (
        .clk_a_i  (meas_clk_i),
        .clk_b_i  (ps_clk),
        .rst_n_i  (rst_n_i),
        .flag_a_i (gate_meas),
        .flag_b_o (done_ps)
    );

    always_ff @(posedge meas_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            edge_cnt_q <= '0;
        end else if (gate_meas) begin
            edge_cnt_q <= '0;
        end else begin
            edge_cnt_q <= edge_cnt_q + 1'b1;
        end
    end

    // Stays put for a whole gate, so ps_clk can sample it after done
    always_ff @(posedge meas_clk_i) begin
        if (gate_meas) begin
            cnt_hold_q <= edge_cnt_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            CH_FIRST: begin
                if (gate_stb_i) begin
                    state_d = CH_WAIT;
                end
            end
            CH_WAIT: begin
                if (done_ps && !gate_stb_i) begin
                    state_d = CH_GOT;
                end
            end
            CH_GOT: begin
                if (gate_stb_i) begin
                    state_d = CH_WAIT;
                end
            end
            default: state_d = CH_FIRST;
        endcase
    end

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CH_FIRST;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            freq_q <= '0;
            upd_q  <= 1'b0;
            dead_q <= 1'b0;
        end else begin
            upd_q <= 1'b0;
            if (state_q == CH_WAIT) begin
                if (done_ps) begin          // Done wins over a gate on the same cycle
                    freq_q <= cnt_hold_q;
                    upd_q  <= 1'b1;
                    dead_q <= 1'b0;
                end else if (gate_stb_i) begin
                    // Previous gate never came back
                    freq_q <= '0;
                    upd_q  <= 1'b1;
                    dead_q <= 1'b1;
                end
            end
        end
    end

    assign freq_o     = freq_q;
    assign freq_upd_o = upd_q;
    assign clk_dead_o = dead_q;

endmodule

/* verilog/gate_timer.sv */
`timescale 1ns/1ns

module gate_timer #(
    parameter freq_meter_pkg::gate_cnt_t GATE_CYCLES = freq_meter_pkg::GATE_CYCLES_DEF
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic gate_stb_o
);

    import freq_meter_pkg::*;

    localparam gate_cnt_t LAST_CNT = GATE_CYCLES - 1'b1;

    gate_cnt_t cnt_q;
    logic      stb_q;

    // Wraps every GATE_CYCLES cycles
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_q == LAST_CNT) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Count sits at zero out of reset, so the first strobe is immediate
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stb_q <= 1'b0;
        end else begin
            stb_q <= (cnt_q == '0);
        end
    end

    assign gate_stb_o = stb_q;

endmodule

/* verilog/flag_sync.sv */
`timescale 1ns/1ns

module flag_sync (
    input  logic clk_a_i,
    input  logic clk_b_i,
    input  logic rst_n_i,
    input  logic flag_a_i,
    output logic flag_b_o
);

    import freq_meter_pkg::*;

    logic                   toggle_a_q;     // Flips once per source pulse
    logic [SYNC_STAGES-1:0] sync_b_q;
    logic                   last_b_q;
    logic                   flag_b_q;

    always_ff @(posedge clk_a_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            toggle_a_q <= 1'b0;
        end else if (flag_a_i) begin
            toggle_a_q <= ~toggle_a_q;
        end
    end

    // Level crosses here, sync_b_q[0] may go metastable
    always_ff @(posedge clk_b_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_b_q <= '0;
            last_b_q <= 1'b0;
            flag_b_q <= 1'b0;
        end else begin
            sync_b_q <= {sync_b_q[SYNC_STAGES-2:0], toggle_a_q};
            last_b_q <= sync_b_q[SYNC_STAGES-1];
            // Either edge of the toggle is one event
            flag_b_q <= sync_b_q[SYNC_STAGES-1] ^ last_b_q;
        end
    end

    assign flag_b_o = flag_b_q;

endmodule

/* verilog/freq_meter_pkg.sv */
package freq_meter_pkg;

    // Measured-clock edges seen within one gate
    typedef logic [31:0] freq_cnt_t;

    // Gate timer count, in ps_clk cycles
    typedef logic [31:0] gate_cnt_t;

    // ps_clk side of a measurement channel
    typedef enum logic [1:0] {
        CH_FIRST = 2'd0,    // No gate since reset
        CH_WAIT  = 2'd1,    // Gate sent, count still in flight
        CH_GOT   = 2'd2     // Count returned
    } chan_state_t;

    // Flops in every synchronizer chain
    localparam int SYNC_STAGES = 3;

    // One second of a 100 MHz ps_clk
    localparam gate_cnt_t GATE_CYCLES_DEF = 32'd100000000;

endpackage
